// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_elink
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= PASS: all tests

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: src/elink_pkg.sv
package elink_pkg;

   // Byte-wide framed link
   localparam int LINK_W = 8;                // Link data width
   typedef logic [LINK_W-1:0] link_byte_t;   // One link beat

   localparam int BEATS = 13;                // Bytes per packet, 104/8
   typedef logic [3:0] beat_t;               // Counts 0..BEATS-1

   // Transmit buffer handshake states
   typedef enum logic [1:0] {
      EMPTY,                                 // Ready for a new packet
      REQ,                                   // Holding packet, req high
      RELEASE                                // Req dropped, waiting for ack low
   } chan_state_t;

   // Arbiter and serializer states
   typedef enum logic [1:0] {
      IDLE,                                  // No grant
      SEND,                                  // Frame high, shifting bytes
      DONE                                   // Ack high until req drops
   } arb_state_t;

   // Channel indices for the grant flag
   localparam logic CH_RD = 1'b0;
   localparam logic CH_WR = 1'b1;

endpackage

// File: src/elink_rx.sv
`timescale 1ns/1ps

module elink_rx
   import emesh_pkg::*, elink_pkg::*;
(
   input  logic          clkin,
   input  logic          reset,
   input  logic          link_frame,    // Marks valid link bytes
   input  link_byte_t    link_data,
   output logic          rx_valid,      // One-cycle pulse, packet complete
   output emesh_packet_t rx_packet
);

   beat_t               beat_q;        // Bytes received in this frame
   logic                valid_q;
   logic                last_beat;
   logic [PACKET_W-1:0] shift_q;       // Deserializer

   assign last_beat = link_frame && (beat_q == beat_t'(BEATS - 1));

   // Beat counter and completion pulse
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         beat_q  <= '0;
         valid_q <= 1'b0;
      end else begin
         valid_q <= last_beat;           // Pulse the cycle after last byte
         if (!link_frame || last_beat)
            beat_q <= '0;                // Early frame drop restarts count
         else
            beat_q <= beat_q + 1'b1;
      end
   end

   // Msb byte arrives first, so shift in from the bottom
   always_ff @(posedge clkin) begin
      if (link_frame)
         shift_q <= {shift_q[PACKET_W-LINK_W-1:0], link_data};
   end

   assign rx_valid  = valid_q;
   assign rx_packet = emesh_packet_t'(shift_q);   // Stable while no frame

endmodule

// File: src/elink_top.sv
`timescale 1ns/1ps

module elink_top
   import emesh_pkg::*, elink_pkg::*;
(
   input  logic          clkin,
   input  logic          reset,
   input  logic          ext_access,    // Held until its wait is low
   input  emesh_packet_t ext_packet,
   output logic          rd_wait,       // Read channel busy
   output logic          wr_wait,       // Write channel busy
   output logic          out_access,    // Read response, no back-pressure
   output emesh_packet_t out_packet
);

   logic          rd_access;
   logic          wr_access;
   logic          req_rd;
   logic          req_wr;
   logic          ack_rd;
   logic          ack_wr;
   emesh_packet_t pkt_rd;
   emesh_packet_t pkt_wr;
   logic          link_frame;
   link_byte_t    link_data;
   logic          rx_valid;
   emesh_packet_t rx_packet;

   // Split by the write bit, packet bit 1
   assign rd_access = ext_access && !ext_packet.write;
   assign wr_access = ext_access &&  ext_packet.write;

   elink_tx_channel rd_chan (
      .clkin(clkin), .reset(reset),
      .in_access(rd_access), .in_packet(ext_packet), .in_wait(rd_wait),
      .req(req_rd), .req_packet(pkt_rd), .ack(ack_rd)
   );

   elink_tx_channel wr_chan (
      .clkin(clkin), .reset(reset),
      .in_access(wr_access), .in_packet(ext_packet), .in_wait(wr_wait),
      .req(req_wr), .req_packet(pkt_wr), .ack(ack_wr)
   );

   // Shared byte link
   elink_tx_arbiter arbiter (
      .clkin(clkin), .reset(reset),
      .req_rd(req_rd), .req_wr(req_wr), .pkt_rd(pkt_rd), .pkt_wr(pkt_wr),
      .ack_rd(ack_rd), .ack_wr(ack_wr),
      .link_frame(link_frame), .link_data(link_data)
   );

   // Far side of the link
   elink_rx rx (
      .clkin(clkin), .reset(reset),
      .link_frame(link_frame), .link_data(link_data),
      .rx_valid(rx_valid), .rx_packet(rx_packet)
   );

   emesh_memory mem (
      .clkin(clkin), .reset(reset),
      .rx_valid(rx_valid), .rx_packet(rx_packet),
      .out_access(out_access), .out_packet(out_packet)
   );

endmodule

// File: src/elink_tx_arbiter.sv
`timescale 1ns/1ps

module elink_tx_arbiter
   import emesh_pkg::*, elink_pkg::*;
(
   input  logic          clkin,
   input  logic          reset,
   input  logic          req_rd,        // Read channel request
   input  logic          req_wr,        // Write channel request
   input  emesh_packet_t pkt_rd,
   input  emesh_packet_t pkt_wr,
   output logic          ack_rd,        // High in DONE for a read grant
   output logic          ack_wr,        // High in DONE for a write grant
   output logic          link_frame,    // High for BEATS cycles per packet
   output link_byte_t    link_data      // Msb byte first
);

   arb_state_t            state_q;
   beat_t                 beat_q;
   logic                  last_q;       // Channel granted most recently
   logic                  pick;         // Channel to grant this cycle
   logic [1:0]            req_vec;
   logic [PACKET_W-1:0]   shift_q;      // Serializer
   emesh_packet_t         pick_pkt;

   assign req_vec = {req_wr, req_rd};    // Indexed by CH_RD / CH_WR

   // Round robin, the channel not served last wins a tie
   always_comb begin
      if (req_vec[CH_RD] && req_vec[CH_WR])
         pick = ~last_q;
      else if (req_vec[CH_WR])
         pick = CH_WR;
      else
         pick = CH_RD;
   end

   assign pick_pkt = (pick == CH_WR) ? pkt_wr : pkt_rd;

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         state_q <= IDLE;
         beat_q  <= '0;
         last_q  <= CH_WR;              // Read goes first after reset
      end else begin
         unique case (state_q)
            IDLE: begin
               if (|req_vec) begin
                  state_q <= SEND;      // First byte next cycle
                  last_q  <= pick;
                  beat_q  <= '0;
               end
            end
            SEND: begin
               beat_q <= beat_q + 1'b1;
               if (beat_q == beat_t'(BEATS - 1))
                  state_q <= DONE;      // Ack after the 13th byte
            end
            DONE: begin
               if (!req_vec[last_q])
                  state_q <= IDLE;      // Ack drops next cycle
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Load on grant, shift one byte per beat
   always_ff @(posedge clkin) begin
      if (state_q == IDLE && (|req_vec))
         shift_q <= pick_pkt;
      else if (state_q == SEND)
         shift_q <= {shift_q[PACKET_W-LINK_W-1:0], {LINK_W{1'b0}}};
   end

   assign link_frame = (state_q == SEND);
   assign link_data  = shift_q[PACKET_W-1 -: LINK_W];   // Top byte on the wire

   // Phase 2 of the handshake, only one channel can be granted
   assign ack_rd = (state_q == DONE) && (last_q == CH_RD);
   assign ack_wr = (state_q == DONE) && (last_q == CH_WR);

endmodule

// File: src/elink_tx_channel.sv
`timescale 1ns/1ps

module elink_tx_channel
   import emesh_pkg::*, elink_pkg::*;
(
   input  logic          clkin,
   input  logic          reset,
   input  logic          in_access,     // Packet offered by the mesh side
   input  emesh_packet_t in_packet,
   output logic          in_wait,       // Buffer busy
   output logic          req,           // Four-phase request to arbiter
   output emesh_packet_t req_packet,    // Held packet, stable while req high
   input  logic          ack            // From arbiter, after last byte sent
);

   chan_state_t   state_q;
   emesh_packet_t pkt_q;
   logic          take;

   // Accept only when the buffer is empty
   assign take = in_access && (state_q == EMPTY);

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         state_q <= EMPTY;
      end else begin
         unique case (state_q)
            EMPTY: begin
               if (take)
                  state_q <= REQ;         // Wait rises next cycle
            end
            REQ: begin
               if (ack)
                  state_q <= RELEASE;     // Phase 3, drop req
            end
            RELEASE: begin
               if (!ack)
                  state_q <= EMPTY;       // Phase 4 seen, free again
            end
            default: state_q <= EMPTY;
         endcase
      end
   end

   // Payload holding register
   always_ff @(posedge clkin) begin
      if (take)
         pkt_q <= in_packet;
   end

   assign in_wait    = (state_q != EMPTY);   // Busy until handshake closes
   assign req        = (state_q == REQ);
   assign req_packet = pkt_q;

endmodule

// File: src/emesh_memory.sv
`timescale 1ns/1ps

module emesh_memory
   import emesh_pkg::*;
(
   input  logic          clkin,
   input  logic          reset,
   input  logic          rx_valid,      // Incoming transaction, no stall
   input  emesh_packet_t rx_packet,
   output logic          out_access,    // Read response pulse
   output emesh_packet_t out_packet
);

   data_t         mem [MEM_DEPTH];     // Word storage
   mem_index_t    idx;
   logic          do_wr;
   logic          do_rd;
   logic          resp_q;
   emesh_packet_t resp_pkt_q;

   assign idx   = rx_packet.dstaddr[9:2];          // Word index
   assign do_wr = rx_valid && rx_packet.write;
   assign do_rd = rx_valid && !rx_packet.write;

   // Storage and response payload
   always_ff @(posedge clkin) begin
      if (do_wr)
         mem[idx] <= rx_packet.data;
      if (do_rd) begin
         resp_pkt_q.srcaddr  <= rx_packet.dstaddr;   // Swap addresses
         resp_pkt_q.dstaddr  <= rx_packet.srcaddr;   // Back to requester
         resp_pkt_q.data     <= mem[idx];
         resp_pkt_q.ctrlmode <= rx_packet.ctrlmode;
         resp_pkt_q.datamode <= rx_packet.datamode;
         resp_pkt_q.write    <= 1'b0;                // Response is a read return
         resp_pkt_q.spare    <= 1'b0;
      end
   end

   // Response strobe, one cycle after a read arrives
   always_ff @(posedge clkin or posedge reset) begin
      if (reset)
         resp_q <= 1'b0;
      else
         resp_q <= do_rd;
   end

   assign out_access = resp_q;
   assign out_packet = resp_pkt_q;

endmodule

// File: src/emesh_pkg.sv
package emesh_pkg;

   // Field types of the mesh packet
   typedef logic [31:0] addr_t;       // Byte address
   typedef logic [31:0] data_t;       // One data word
   typedef logic [3:0]  ctrlmode_t;   // Control mode bits
   typedef logic [1:0]  datamode_t;   // Access size, always a word here

   // Packet layout, msb first
   typedef struct packed {
      addr_t     srcaddr;             // Bits 103:72, return address
      data_t     data;                // Bits 71:40
      addr_t     dstaddr;             // Bits 39:8, target address
      ctrlmode_t ctrlmode;            // Bits 7:4
      datamode_t datamode;            // Bits 3:2
      logic      write;               // Bit 1, selects write channel
      logic      spare;               // Bit 0, unused
   } emesh_packet_t;

   localparam int PACKET_W = 104;     // Must match the struct above

   // Remote memory geometry
   localparam int MEM_DEPTH = 256;    // Words
   typedef logic [7:0] mem_index_t;   // From dstaddr[9:2]

endpackage

// File: tb/elink_checker.sv
`timescale 1ns/1ps

module elink_checker
   import elink_pkg::*;
(
   input logic clkin,
   input logic reset,
   input logic req_rd,
   input logic req_wr,
   input logic ack_rd,
   input logic ack_wr,
   input logic link_frame
);

   logic [4:0] frame_len;                    // Cycles of the current frame

   always_ff @(posedge clkin or posedge reset) begin
      if (reset)
         frame_len <= '0;
      else if (link_frame)
         frame_len <= frame_len + 1'b1;
      else
         frame_len <= '0;
   end

   frame_not_long: assert property (@(posedge clkin) disable iff (reset)
      link_frame |-> frame_len < 5'(BEATS))
      else $error("link frame ran past %0d cycles", BEATS);

   // Checked on the first cycle after the frame drops
   frame_exact: assert property (@(posedge clkin) disable iff (reset)
      (!link_frame && frame_len != 5'd0) |-> frame_len == 5'(BEATS))
      else $error("link frame lasted %0d cycles", frame_len);

   ack_rd_needs_req: assert property (@(posedge clkin) disable iff (reset)
      $rose(ack_rd) |-> req_rd)
      else $error("read ack rose without a read request");

   ack_wr_needs_req: assert property (@(posedge clkin) disable iff (reset)
      $rose(ack_wr) |-> req_wr)
      else $error("write ack rose without a write request");

   req_rd_held: assert property (@(posedge clkin) disable iff (reset)
      $fell(req_rd) |-> $past(ack_rd))
      else $error("read request dropped before its ack");

   req_wr_held: assert property (@(posedge clkin) disable iff (reset)
      $fell(req_wr) |-> $past(ack_wr))
      else $error("write request dropped before its ack");

   ack_onehot: assert property (@(posedge clkin) disable iff (reset)
      !(ack_rd && ack_wr))
      else $error("both acks high together");

endmodule

bind elink_tx_arbiter elink_checker chk (
   .clkin(clkin), .reset(reset),
   .req_rd(req_rd), .req_wr(req_wr),
   .ack_rd(ack_rd), .ack_wr(ack_wr),
   .link_frame(link_frame)
);

// File: tb/tb_elink.sv
`timescale 1ns/1ps

module tb_elink
   import emesh_pkg::*;
();

   localparam int    WAIT_LIMIT = 100;             // Cycles allowed per handshake wait
   localparam int    RESP_LIMIT = 1000;            // Cycles allowed per response
   localparam int    FILL_N     = 16;              // Words in the fill test
   localparam addr_t FILL_SRC   = 32'h4000_0100;   // Requester address for fill reads

   logic          clkin;
   logic          reset;
   logic          ext_access;
   emesh_packet_t ext_packet;
   logic          rd_wait;
   logic          wr_wait;
   logic          out_access;
   emesh_packet_t out_packet;

   int            errors;
   int            test_start_errors;
   int            tests_run;
   int            tests_failed;
   string         test_name;
   logic [31:0]   rng;                       // Xorshift state
   data_t         model_mem [MEM_DEPTH];     // Expected memory contents
   addr_t         fill_addr [FILL_N];        // Reused by later tests
   emesh_packet_t resp_q [$];                // Responses seen on the output

   elink_top dut (
      .clkin(clkin), .reset(reset),
      .ext_access(ext_access), .ext_packet(ext_packet),
      .rd_wait(rd_wait), .wr_wait(wr_wait),
      .out_access(out_access), .out_packet(out_packet)
   );

   always #5 clkin = ~clkin;                 // 10 ns period

   // Response monitor, samples away from the active edge
   always @(negedge clkin) begin
      if (out_access)
         resp_q.push_back(out_packet);
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function logic [31:0] rand_word();
      rng = xorshift32(rng);
      return rng;
   endfunction

   function automatic emesh_packet_t make_write(input addr_t addr, input data_t data);
      emesh_packet_t p;
      p          = '0;
      p.dstaddr  = addr;
      p.data     = data;
      p.datamode = 2'b10;                    // Word access
      p.write    = 1'b1;
      return p;
   endfunction

   function automatic emesh_packet_t make_read(input addr_t addr, input addr_t src,
                                               input ctrlmode_t ctrl);
      emesh_packet_t p;
      p          = '0;
      p.srcaddr  = src;                      // Where the response goes
      p.dstaddr  = addr;
      p.ctrlmode = ctrl;
      p.datamode = 2'b10;
      return p;
   endfunction

   task automatic next_cycle();
      @(posedge clkin);
      #1;                                    // Drive and sample 1 ns after the edge
   endtask

   task automatic compare_word(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
      assert (actual === expected) else begin
         errors++;
         $display("** Error %s: %s expected %h, actual %h",
                  test_name, what, expected, actual);
      end
   endtask

   task automatic expect_flag(input logic ok, input string what);
      assert (ok) else begin
         errors++;
         $display("%s: %s", test_name, what);
      end
   endtask

   // Hold access and packet until an edge with the class wait low
   task automatic send_packet(input emesh_packet_t pkt);
      int   cycles;
      logic busy;
      cycles     = 0;
      ext_packet = pkt;
      ext_access = 1'b1;
      busy       = pkt.write ? wr_wait : rd_wait;
      while (busy && cycles < WAIT_LIMIT) begin
         next_cycle();
         cycles++;
         busy = pkt.write ? wr_wait : rd_wait;
      end
      next_cycle();                          // Taken on this edge
      ext_access = 1'b0;
      expect_flag(!busy, "the channel did not accept the packet before the timeout");
   endtask

   task automatic wait_channel_idle(input logic is_write);
      int cycles;
      cycles = 0;
      while ((is_write ? wr_wait : rd_wait) && cycles < WAIT_LIMIT) begin
         next_cycle();
         cycles++;
      end
      expect_flag(!(is_write ? wr_wait : rd_wait),
                  "the channel wait did not go low before the timeout");
   endtask

   task automatic next_response(output emesh_packet_t pkt);
      int cycles;
      cycles = 0;
      while (resp_q.size() == 0 && cycles < RESP_LIMIT) begin
         next_cycle();
         cycles++;
      end
      expect_flag(resp_q.size() != 0, "no read response was seen before the timeout");
      if (resp_q.size() != 0)
         pkt = resp_q.pop_front();
      else
         pkt = '0;
   endtask

   // Response header rules, addresses swapped
   task automatic verify_response(input emesh_packet_t pkt, input addr_t addr,
                                  input addr_t src, input ctrlmode_t ctrl, input data_t data);
      compare_word("data", data, pkt.data);
      compare_word("srcaddr", addr, pkt.srcaddr);
      compare_word("dstaddr", src, pkt.dstaddr);
      compare_word("ctrlmode", 32'(ctrl), 32'(pkt.ctrlmode));
      compare_word("datamode", 32'h2, 32'(pkt.datamode));
      compare_word("write", 32'h0, 32'(pkt.write));
   endtask

   task automatic write_word(input addr_t addr, input data_t data);
      send_packet(make_write(addr, data));
      model_mem[addr[9:2]] = data;           // Word index from dstaddr
      wait_channel_idle(1'b1);
   endtask

   task automatic begin_test(input string name);
      test_name         = name;
      test_start_errors = errors;
      tests_run++;
      resp_q.delete();
   endtask

   task automatic end_test();
      if (errors == test_start_errors) begin
         $display("%s: ok", test_name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", test_name, errors - test_start_errors);
      end
   endtask

   task automatic reset_state();
      begin_test("reset_state");
      compare_word("rd_wait", 32'h0, 32'(rd_wait));
      compare_word("wr_wait", 32'h0, 32'(wr_wait));
      compare_word("out_access", 32'h0, 32'(out_access));
      repeat (20) next_cycle();              // Idle, nothing may come out
      compare_word("response count", 32'h0, 32'(resp_q.size()));
      end_test();
   endtask

   task automatic write_then_read();
      addr_t         addr;
      emesh_packet_t pkt;
      begin_test("write_then_read");
      addr = 32'h0000_0040;
      write_word(addr, rand_word());
      send_packet(make_read(addr, 32'h8000_0000, 4'h0));
      next_response(pkt);
      verify_response(pkt, addr, 32'h8000_0000, 4'h0, model_mem[addr[9:2]]);
      repeat (30) next_cycle();              // Room for a stray second response
      compare_word("extra responses", 32'h0, 32'(resp_q.size()));
      end_test();
   endtask

   task automatic random_fill_readback();
      logic          used [MEM_DEPTH];
      logic [31:0]   r;
      int            i;
      int            tries;
      emesh_packet_t pkt;
      begin_test("random_fill_readback");
      foreach (used[k])
         used[k] = 1'b0;
      for (i = 0; i < FILL_N; i++) begin
         r     = rand_word();
         tries = 0;
         while (used[r[9:2]] && tries < 64) begin   // Distinct word index
            r = rand_word();
            tries++;
         end
         used[r[9:2]] = 1'b1;
         fill_addr[i] = {r[31:2], 2'b00};
         write_word(fill_addr[i], rand_word());
      end
      for (i = 0; i < FILL_N; i++)
         send_packet(make_read(fill_addr[i], FILL_SRC, 4'h0));
      for (i = 0; i < FILL_N; i++) begin     // Issue order
         next_response(pkt);
         verify_response(pkt, fill_addr[i], FILL_SRC, 4'h0, model_mem[fill_addr[i][9:2]]);
      end
      end_test();
   endtask

   task automatic response_header();
      addr_t         addr;
      emesh_packet_t pkt;
      begin_test("response_header");
      addr = fill_addr[3];
      send_packet(make_read(addr, 32'hc0de_0100, 4'ha));
      next_response(pkt);
      verify_response(pkt, addr, 32'hc0de_0100, 4'ha, model_mem[addr[9:2]]);
      end_test();
   endtask

   // Single input port, so the write goes in right behind the read
   task automatic overlapped_read_write();
      addr_t         rd_addr;
      addr_t         wr_addr;
      data_t         old_data;
      data_t         new_data;
      logic          rd_seen;
      logic          wr_seen;
      int            cycles;
      emesh_packet_t pkt;
      begin_test("overlapped_read_write");
      rd_addr  = fill_addr[5];
      wr_addr  = fill_addr[6];
      old_data = model_mem[rd_addr[9:2]];
      new_data = ~model_mem[wr_addr[9:2]];   // Differs from the stored word
      send_packet(make_read(rd_addr, 32'h2000_0000, 4'h1));
      rd_seen = rd_wait;                     // Busy from the cycle after acceptance
      send_packet(make_write(wr_addr, new_data));
      wr_seen = wr_wait;
      model_mem[wr_addr[9:2]] = new_data;
      cycles = 0;
      while ((rd_wait || wr_wait) && cycles < WAIT_LIMIT) begin
         next_cycle();
         cycles++;
      end
      expect_flag(rd_seen && wr_seen, "a channel wait was not high after its packet was taken");
      expect_flag(!rd_wait && !wr_wait, "the channel waits did not both go low before the timeout");
      next_response(pkt);
      verify_response(pkt, rd_addr, 32'h2000_0000, 4'h1, old_data);
      send_packet(make_read(wr_addr, 32'h2000_0004, 4'h1));
      next_response(pkt);
      verify_response(pkt, wr_addr, 32'h2000_0004, 4'h1, new_data);
      end_test();
   endtask

   initial begin
      clkin        = 1'b0;
      reset        = 1'b1;
      ext_access   = 1'b0;
      ext_packet   = '0;
      rng          = 32'h6a98_61c8;          // Fixed seed
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (10) @(posedge clkin);
      #1;
      reset = 1'b0;
      reset_state();
      write_then_read();
      random_fill_readback();
      response_header();
      overlapped_read_write();
      $display("Summary: %0d tests run, %0d failed, %0d errors",
               tests_run, tests_failed, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// File: vlog.f
src/emesh_pkg.sv
src/elink_pkg.sv
src/elink_tx_channel.sv
src/elink_tx_arbiter.sv
src/elink_rx.sv
src/emesh_memory.sv
src/elink_top.sv
tb/elink_checker.sv
tb/tb_elink.sv
